//--- hdl/permPipe_consts.svh
`ifndef PERMPIPE_CONSTS_SVH
`define PERMPIPE_CONSTS_SVH

// Number of identical compute lanes
`define LANE_COUNT 4

// Cycles from lane write to lane FIFO write
`define LANE_LATENCY 4

// Results a lane may hold, in flight plus buffered
`define LANE_DEPTH 8
`define LANE_MARGIN 2 // Almost-full headroom

// Origin queue, 32 entries
`define ORIGIN_DEPTH_LOG2 5

// Collector output buffer
`define OUT_DEPTH_LOG2 3

`endif

//--- hdl/permPipePkg.sv
`include "permPipe_consts.svh"

package permPipePkg;

    // Top and bot words share one format
    typedef logic [127:0] word_t;

    typedef logic [47:0] pcoeffSum_t;
    typedef logic [12:0] pcoeffCount_t;

    // Count in the upper 13 bits, sum in the lower 48
    typedef logic [60:0] result_t;

    // One bit per lane, at most one set
    typedef logic [`LANE_COUNT-1:0] laneSel_t;

    // Dispatcher FSM
    typedef enum logic {
        RUN,    // Bots and tops accepted
        TOPWAIT // New top waiting for the lanes to drain
    } dispState_t;

endpackage

//--- hdl/laneIf.sv
`timescale 1ns/1ps

interface laneIf
    import permPipePkg::*;
();

    // Input side
    word_t   bot;
    logic    write;
    logic    almostFull;

    // Output side, first-word-fall-through
    logic    readRequest;
    logic    empty;
    result_t result;

    modport dispatch (
        output bot,
        output write,
        input  almostFull
    );

    modport lane (
        input  bot,
        input  write,
        output almostFull,
        input  readRequest,
        output empty,
        output result
    );

    modport collect (
        output readRequest,
        input  empty,
        input  result
    );

endinterface

//--- hdl/syncFifo.sv
`timescale 1ns/1ps

module syncFifo #(
    parameter int WIDTH      = 8,
    parameter int DEPTH_LOG2 = 3
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  writeEnable,
    input  logic [WIDTH-1:0]      dataIn,
    input  logic                  readEnable,
    output logic [WIDTH-1:0]      dataOut,
    output logic                  empty,
    output logic                  full,
    output logic [DEPTH_LOG2:0]   count
);

    localparam int DEPTH = 1 << DEPTH_LOG2;

    logic [WIDTH-1:0]      mem [DEPTH];
    logic [DEPTH_LOG2-1:0] writePtr;
    logic [DEPTH_LOG2-1:0] readPtr;
    logic                  doWrite;
    logic                  doRead;

    assign doWrite = writeEnable && !full; // Writes into a full FIFO are dropped
    assign doRead  = readEnable && !empty;

    always_ff @(posedge clk) begin
        if (doWrite) begin
            mem[writePtr] <= dataIn;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            writePtr <= '0;
            readPtr  <= '0;
            count    <= '0;
        end else begin
            if (doWrite) writePtr <= writePtr + 1'b1;
            if (doRead) readPtr <= readPtr + 1'b1;
            if (doWrite && !doRead) begin
                count <= count + 1'b1;
            end else if (doRead && !doWrite) begin
                count <= count - 1'b1;
            end
        end
    end

    // Head word is visible before it is read
    assign dataOut = mem[readPtr];
    assign empty   = (count == 0);
    assign full    = (count == DEPTH);

endmodule

//--- hdl/botDispatcher.sv
`timescale 1ns/1ps
`include "permPipe_consts.svh"

module botDispatcher
    import permPipePkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     inValid,
    input  word_t    inData,
    input  logic     startNewTop,
    input  logic     idle,
    output logic     inReady,
    output word_t    top,
    output logic     originWrite,
    output laneSel_t originLane,
    laneIf.dispatch  lanes [`LANE_COUNT]
);

    dispState_t state;
    laneSel_t   rrPointer;  // Lane to try first
    laneSel_t   laneFull;
    laneSel_t   target;     // Lane that takes the next bot, zero if none
    logic       topTransfer;
    logic       botTransfer;

    for (genvar i = 0; i < `LANE_COUNT; i++) begin : laneConn
        assign laneFull[i]    = lanes[i].almostFull;
        assign lanes[i].bot   = inData;
        assign lanes[i].write = botTransfer && target[i];
    end

    // First lane at or after the pointer that still has room
    always_comb begin
        laneSel_t candidate;
        target    = '0;
        candidate = rrPointer;
        for (int i = 0; i < `LANE_COUNT; i++) begin
            if (target == '0 && (candidate & ~laneFull) != '0) begin
                target = candidate;
            end
            candidate = {candidate[`LANE_COUNT-2:0], candidate[`LANE_COUNT-1]};
        end
    end

    // A top waits for every outstanding bot to come out
    assign inReady     = (state == RUN) && (startNewTop ? idle : (target != '0));
    assign topTransfer = inValid && inReady && startNewTop;
    assign botTransfer = inValid && inReady && !startNewTop;

    assign originWrite = botTransfer;
    assign originLane  = target;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= RUN;
        end else begin
            case (state)
                RUN:     if (inValid && startNewTop && !idle) state <= TOPWAIT;
                TOPWAIT: if (idle) state <= RUN;
                default: state <= RUN;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            top       <= '0;
            rrPointer <= laneSel_t'(1); // Lane 0 first
        end else begin
            if (topTransfer) top <= inData;
            if (botTransfer) begin
                rrPointer <= {target[`LANE_COUNT-2:0], target[`LANE_COUNT-1]};
            end
        end
    end

endmodule

//--- hdl/permutationLane.sv
`timescale 1ns/1ps
`include "permPipe_consts.svh"

module permutationLane
    import permPipePkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  word_t top,
    laneIf.lane   port
);

    localparam int FIFO_LOG2 = $clog2(`LANE_DEPTH);

    word_t andBits;
    word_t xorBits;
    logic  valid0;

    // Per 32-bit quarter
    logic [5:0]  partCount [4];
    logic [16:0] partSum [4];
    logic        valid1;

    pcoeffCount_t countTotal;
    pcoeffSum_t   sumTotal;
    result_t      stageData [2:`LANE_LATENCY-1];
    logic [`LANE_LATENCY-1:2] stageValid;

    logic [FIFO_LOG2:0] credit; // Bots written and not yet read back

    always_ff @(posedge clk) begin
        andBits <= port.bot & top;
        xorBits <= port.bot ^ top;
        for (int q = 0; q < 4; q++) begin
            partCount[q] <= 6'($countones(andBits[q*32 +: 32]));
            partSum[q]   <= {1'b0, xorBits[q*32 +: 16]} + {1'b0, xorBits[q*32+16 +: 16]};
        end
        stageData[2] <= {countTotal, sumTotal};
        for (int k = 3; k < `LANE_LATENCY; k++) begin
            stageData[k] <= stageData[k-1];
        end
    end

    // Final reduction feeds stage 2
    always_comb begin
        countTotal = '0;
        sumTotal   = '0;
        for (int q = 0; q < 4; q++) begin
            countTotal = countTotal + pcoeffCount_t'(partCount[q]);
            sumTotal   = sumTotal + pcoeffSum_t'(partSum[q]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid0     <= 1'b0;
            valid1     <= 1'b0;
            stageValid <= '0;
        end else begin
            valid0     <= port.write;
            valid1     <= valid0;
            stageValid <= {stageValid[`LANE_LATENCY-2:2], valid1};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            credit <= '0;
        end else if (port.write && !port.readRequest) begin
            credit <= credit + 1'b1;
        end else if (port.readRequest && !port.write) begin
            credit <= credit - 1'b1;
        end
    end

    // Margin keeps the FIFO from ever filling
    assign port.almostFull = (credit >= (`LANE_DEPTH - `LANE_MARGIN));

    syncFifo #(
        .WIDTH      ($bits(result_t)),
        .DEPTH_LOG2 (FIFO_LOG2)
    ) resultFifo (
        .clk         (clk),
        .rst         (rst),
        .writeEnable (stageValid[`LANE_LATENCY-1]),
        .dataIn      (stageData[`LANE_LATENCY-1]),
        .readEnable  (port.readRequest),
        .dataOut     (port.result),
        .empty       (port.empty),
        .full        (),
        .count       ()
    );

endmodule

//--- hdl/resultCollector.sv
`timescale 1ns/1ps
`include "permPipe_consts.svh"

module resultCollector
    import permPipePkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     originWrite,
    input  laneSel_t originLane,
    input  logic     outReady,
    output logic     idle,
    output logic     outValid,
    output result_t  outData,
    laneIf.collect   lanes [`LANE_COUNT]
);

    laneSel_t                originHead; // Lane holding the oldest result
    logic                    originEmpty;
    logic [`LANE_COUNT-1:0]  laneEmpty;
    result_t                 laneResult [`LANE_COUNT];
    result_t                 selResult;
    logic                    grab;
    logic                    outEmpty;
    logic                    outFull;

    // Entries never exceed lane count times lane depth
    syncFifo #(
        .WIDTH      (`LANE_COUNT),
        .DEPTH_LOG2 (`ORIGIN_DEPTH_LOG2)
    ) originQueue (
        .clk         (clk),
        .rst         (rst),
        .writeEnable (originWrite),
        .dataIn      (originLane),
        .readEnable  (grab),
        .dataOut     (originHead),
        .empty       (originEmpty),
        .full        (),
        .count       ()
    );

    for (genvar i = 0; i < `LANE_COUNT; i++) begin : laneConn
        assign laneEmpty[i]         = lanes[i].empty;
        assign laneResult[i]        = lanes[i].result;
        assign lanes[i].readRequest = grab && originHead[i];
    end

    // Only the lane named by the origin head may be read
    assign grab = !originEmpty && ((originHead & ~laneEmpty) != '0) && !outFull;

    always_comb begin
        selResult = '0;
        for (int i = 0; i < `LANE_COUNT; i++) begin
            if (originHead[i]) selResult = selResult | laneResult[i];
        end
    end

    syncFifo #(
        .WIDTH      ($bits(result_t)),
        .DEPTH_LOG2 (`OUT_DEPTH_LOG2)
    ) outFifo (
        .clk         (clk),
        .rst         (rst),
        .writeEnable (grab),
        .dataIn      (selResult),
        .readEnable  (outValid && outReady),
        .dataOut     (outData),   // Holds until popped
        .empty       (outEmpty),
        .full        (outFull),
        .count       ()
    );

    assign outValid = !outEmpty;

    // Nothing in flight and nothing buffered in a lane
    assign idle = originEmpty && (&laneEmpty);

endmodule

//--- hdl/permPipeTop.sv
`timescale 1ns/1ps
`include "permPipe_consts.svh"

module permPipeTop
    import permPipePkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    inValid,
    input  word_t   inData,
    input  logic    startNewTop,
    input  logic    outReady,
    output logic    inReady,
    output logic    outValid,
    output result_t outData
);

    laneIf laneBus [`LANE_COUNT] ();

    word_t    top;          // Broadcast to all lanes
    logic     idle;
    logic     originWrite;
    laneSel_t originLane;

    botDispatcher dispatcher (
        .clk         (clk),
        .rst         (rst),
        .inValid     (inValid),
        .inData      (inData),
        .startNewTop (startNewTop),
        .idle        (idle),
        .inReady     (inReady),
        .top         (top),
        .originWrite (originWrite),
        .originLane  (originLane),
        .lanes       (laneBus)
    );

    // One compute lane per interface
    for (genvar i = 0; i < `LANE_COUNT; i++) begin : laneGen
        permutationLane lane (
            .clk  (clk),
            .rst  (rst),
            .top  (top),
            .port (laneBus[i])
        );
    end

    resultCollector collector (
        .clk         (clk),
        .rst         (rst),
        .originWrite (originWrite),
        .originLane  (originLane),
        .outReady    (outReady),
        .idle        (idle),
        .outValid    (outValid),
        .outData     (outData),
        .lanes       (laneBus)
    );

endmodule

//--- tests/permPipeTb.sv
`timescale 1ns/1ps
`include "permPipe_consts.svh"

module permPipeTb
    import permPipePkg::*;
();

    localparam int NUM_ITEMS   = 400;
    localparam int STALL_LEN   = 100; // Cycles of blocked output
    localparam int WATCH_LIMIT = NUM_ITEMS * 40 + 1000;

    logic    clk;
    logic    rst;
    logic    inValid;
    word_t   inData;
    logic    startNewTop;
    logic    outReady;
    logic    inReady;
    logic    outValid;
    result_t outData;

    logic [31:0] lcgState;
    word_t       modelTop;
    result_t     expected [$];
    int          cycle;
    int          issued;
    int          cyclesSinceBot;
    int          topsHeld;
    int          stallStart;
    logic        inAccepted;
    logic        sawBackpressure;
    logic        holdValid;
    result_t     heldData;

    permPipeTop DUT (
        .clk         (clk),
        .rst         (rst),
        .inValid     (inValid),
        .inData      (inData),
        .startNewTop (startNewTop),
        .outReady    (outReady),
        .inReady     (inReady),
        .outValid    (outValid),
        .outData     (outData)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic word_t randWord();
        word_t w;
        for (int i = 0; i < 4; i++) begin
            w[i*32 +: 32] = nextRand();
        end
        return w;
    endfunction

    // Count of common set bits and sum of the XOR fields
    function automatic result_t modelResult(input word_t bot, input word_t topWord);
        pcoeffCount_t cnt;
        pcoeffSum_t   sum;
        word_t        diff;
        cnt  = '0;
        sum  = '0;
        diff = bot ^ topWord;
        for (int b = 0; b < 128; b++) begin
            if (bot[b] && topWord[b]) cnt = cnt + 1'b1;
        end
        for (int f = 0; f < 8; f++) begin
            sum = sum + diff[f*16 +: 16];
        end
        return {cnt, sum};
    endfunction

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [63:0] actual,
                         input logic [63:0] want);
        if (actual !== want) begin
            failRun($sformatf("mismatch %s: got %h, expected %h", name, actual, want));
        end
    endtask

    function automatic logic stallActive();
        return (stallStart >= 0) && (cycle < stallStart + STALL_LEN);
    endfunction

    // Called at the falling edge, where all handshake signals are settled
    task automatic observe();
        result_t exp;
        cyclesSinceBot++;
        if (holdValid && outValid) check("outData", outData, heldData); // Held under stall
        inAccepted = inValid && inReady;
        if (inValid && startNewTop && !inReady) topsHeld++;
        if (stallActive() && inValid && !startNewTop && !inReady) sawBackpressure = 1'b1;
        if (inAccepted) begin
            if (startNewTop) begin
                if (cyclesSinceBot <= `LANE_LATENCY) begin
                    failRun("top word accepted while bots were still in the lanes");
                end
                modelTop = inData;
            end else begin
                expected.push_back(modelResult(inData, modelTop));
                cyclesSinceBot = 0;
            end
        end
        if (outValid && outReady) begin
            if (expected.size() == 0) failRun("result delivered with none outstanding");
            exp = expected.pop_front();
            check("outData", outData, exp);
        end
        holdValid = outValid && !outReady;
        heldData  = outData;
    endtask

    // Called 1 ns after the rising edge
    task automatic driveNext();
        logic [31:0] r;
        if (stallStart < 0 && cycle >= 150 && !(inValid && startNewTop)) stallStart = cycle;
        r = nextRand();
        outReady = stallActive() ? 1'b0 : (r[9:8] != 2'b00);
        if (inValid && !inAccepted) return; // Hold until taken
        if (issued >= NUM_ITEMS || (!stallActive() && r[2:0] == 3'd0)) begin
            inValid = 1'b0;
        end else begin
            inValid     = 1'b1;
            inData      = randWord();
            startNewTop = (issued >= 8) && !stallActive() && (r[7:4] == 4'd0);
            issued++;
        end
    endtask

    initial begin
        repeat (WATCH_LIMIT) @(posedge clk);
        failRun($sformatf("timeout after %0d cycles, run did not finish", WATCH_LIMIT));
    end

    initial begin
        lcgState        = 32'd54642;
        rst             = 1'b1;
        inValid         = 1'b0;
        inData          = '0;
        startNewTop     = 1'b0;
        outReady        = 1'b0;
        modelTop        = '0;
        cycle           = 0;
        issued          = 0;
        cyclesSinceBot  = 1000;
        topsHeld        = 0;
        stallStart      = -1;
        inAccepted      = 1'b0;
        sawBackpressure = 1'b0;
        holdValid       = 1'b0;
        heldData        = '0;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
        @(negedge clk);
        check("outValid", outValid, 0);
        check("inReady", inReady, 1);
        @(posedge clk);
        #1 driveNext();
        while (!(issued == NUM_ITEMS && !inValid && expected.size() == 0)) begin
            @(negedge clk);
            observe();
            @(posedge clk);
            #1;
            cycle++;
            driveNext();
        end
        // Drained, output must stay quiet
        outReady = 1'b1;
        repeat (20) begin
            @(negedge clk);
            check("outValid", outValid, 0);
        end
        if (!sawBackpressure) begin
            failRun("inReady never dropped while the output was blocked");
        end else if (topsHeld == 0) begin
            failRun("no top word was ever held off by outstanding bots");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

//--- permPipe.f
+incdir+hdl
hdl/permPipePkg.sv
hdl/laneIf.sv
hdl/syncFifo.sv
hdl/botDispatcher.sv
hdl/permutationLane.sv
hdl/resultCollector.sv
hdl/permPipeTop.sv
tests/permPipeTb.sv
